// File: Bender.yml
package:
  name: uart_echo

sources:
  # RTL, package first
  - logic/uart_pkg.sv
  - logic/baud_tick_gen.sv
  - logic/uart_receiver.sv
  - logic/byte_fifo.sv
  - logic/echo_controller.sv
  - logic/uart_transmitter.sv
  - logic/uart_echo_top.sv

  # Testbench, top module uart_echo_tb
  - target: simulation
    files:
      - tb/uart_echo_properties.sv
      - tb/uart_echo_tb.sv

// File: logic/baud_tick_gen.sv
`timescale 1ns/1ns
`default_nettype none

module baud_tick_gen #(
	parameter int CLKS_PER_TICK = 651
) (
	input  logic clk,
	input  logic rst,
	output logic tick
);

	// Counter wide enough for the reload value
	localparam int CW = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;
	localparam logic [CW-1:0] RELOAD = CW'(CLKS_PER_TICK - 1);

	logic [CW-1:0] count;

	// Down-counter, reloads after hitting zero
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			count <= RELOAD;
		end
		else if (count == '0)
		begin
			count <= RELOAD;
		end
		else
		begin
			count <= count - 1'b1;
		end
	end

	// One clk wide enable, once per CLKS_PER_TICK cycles
	assign tick = (count == '0);

endmodule

`default_nettype wire

// File: logic/byte_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module byte_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                 clk,
	input  logic                 rst,
	input  uart_pkg::byte_beat_t push,
	input  logic                 pop,
	output logic [7:0]           head,
	output logic                 empty,
	output logic                 full
);
	import uart_pkg::*;

	// Depth is a power of two, pointers wrap on their own
	localparam int AW = $clog2(FIFO_DEPTH);
	localparam logic [AW:0] FULL_COUNT = (AW + 1)'(FIFO_DEPTH);

	logic [DATA_BITS-1:0] mem [FIFO_DEPTH];
	logic [AW-1:0]        wr_ptr;
	logic [AW-1:0]        rd_ptr;
	logic [AW:0]          count;
	logic                 do_push;
	logic                 do_pop;

	// Self protection against overflow and underflow
	assign do_push = push.valid && !full;
	assign do_pop  = pop && !empty;

	// Pointers and occupancy
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous push and pop leaves count alone
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= push.data;
	end

	// Fall-through head and count based flags
	assign head  = mem[rd_ptr];
	assign empty = (count == '0);
	assign full  = (count == FULL_COUNT);

endmodule

`default_nettype wire

// File: logic/echo_controller.sv
`timescale 1ns/1ns
`default_nettype none

module echo_controller (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [7:0]            rx_head,
	input  logic                  rx_empty,
	input  logic                  tx_full,
	output logic                  rx_pop,
	output uart_pkg::byte_beat_t  tx_beat,
	output uart_pkg::echo_state_t state
);
	import uart_pkg::*;

	// Fetched byte, held through back-pressure
	logic [DATA_BITS-1:0] held;

	//////////////////////////////////////////////////
	// Echo state machine
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ECHO_IDLE;
		end
		else
		begin
			case (state)
				ECHO_IDLE:
				begin
					// Something waiting in the receive FIFO
					if (!rx_empty)
						state <= ECHO_FETCH;
				end
				ECHO_FETCH:
				begin
					// Pop happens during this single cycle
					state <= ECHO_SEND;
				end
				ECHO_SEND:
				begin
					// Stall here while transmit side is full
					if (!tx_full)
						state <= ECHO_IDLE;
				end
				default:
					state <= ECHO_IDLE;
			endcase
		end
	end

	// Capture head on the pop cycle
	always_ff @(posedge clk)
	begin
		if (state == ECHO_FETCH)
			held <= rx_head;
	end

	// Strobes decoded from state
	assign rx_pop = (state == ECHO_FETCH);

	// Push only when there is room
	assign tx_beat = '{valid: (state == ECHO_SEND) && !tx_full, data: held};

endmodule

`default_nettype wire

// File: logic/uart_echo_top.sv
`timescale 1ns/1ns
`default_nettype none

module uart_echo_top #(
	parameter int CLKS_PER_TICK = 651,
	parameter int FIFO_DEPTH    = 16
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  rx,
	output logic                  tx,
	output uart_pkg::echo_state_t echo_state
);
	import uart_pkg::*;

	// Oversample enable
	logic tick;

	// Receive path
	byte_beat_t           rx_beat;
	logic [DATA_BITS-1:0] rx_head;
	logic                 rx_empty;
	logic                 rx_pop;

	// Transmit path
	byte_beat_t           tx_beat;
	logic [DATA_BITS-1:0] tx_head;
	logic                 tx_empty;
	logic                 tx_full;
	logic                 tx_pop;
	logic                 tx_line;

	echo_state_t ctrl_state;

	//////////////////////////////////////////////////
	// Block instances
	//////////////////////////////////////////////////

	baud_tick_gen #(
		.CLKS_PER_TICK (CLKS_PER_TICK)
	) i_baud (
		.clk  (clk),
		.rst  (rst),
		.tick (tick)
	);

	uart_receiver i_receiver (
		.clk     (clk),
		.rst     (rst),
		.tick    (tick),
		.rx      (rx),
		.rx_beat (rx_beat)
	);

	// Drained faster than the line can fill it, so full stays open
	byte_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_rx_fifo (
		.clk   (clk),
		.rst   (rst),
		.push  (rx_beat),
		.pop   (rx_pop),
		.head  (rx_head),
		.empty (rx_empty),
		.full  ()
	);

	echo_controller i_controller (
		.clk      (clk),
		.rst      (rst),
		.rx_head  (rx_head),
		.rx_empty (rx_empty),
		.tx_full  (tx_full),
		.rx_pop   (rx_pop),
		.tx_beat  (tx_beat),
		.state    (ctrl_state)
	);

	byte_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_tx_fifo (
		.clk   (clk),
		.rst   (rst),
		.push  (tx_beat),
		.pop   (tx_pop),
		.head  (tx_head),
		.empty (tx_empty),
		.full  (tx_full)
	);

	uart_transmitter i_transmitter (
		.clk      (clk),
		.rst      (rst),
		.tick     (tick),
		.tx_head  (tx_head),
		.tx_empty (tx_empty),
		.tx_pop   (tx_pop),
		.tx_line  (tx_line)
	);

	// Output registers, one clk behind their sources
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			tx         <= 1'b1;
			echo_state <= ECHO_IDLE;
		end
		else
		begin
			tx         <= tx_line;
			echo_state <= ctrl_state;
		end
	end

endmodule

`default_nettype wire

// File: logic/uart_pkg.sv
`default_nettype none

package uart_pkg;

	//////////////////////////////////////////////////
	// Frame constants
	//////////////////////////////////////////////////

	// Data bits per frame, sent LSB first
	localparam int DATA_BITS = 8;

	// Oversample ticks per bit period
	localparam int OVERSAMPLE = 16;

	// Ticks from start edge to middle of start bit
	localparam int HALF_BIT = 8;

	//////////////////////////////////////////////////
	// Shared types
	//////////////////////////////////////////////////

	// One byte on its way between blocks
	// valid is high for a single clk
	typedef struct packed {
		logic                 valid;
		logic [DATA_BITS-1:0] data;
	} byte_beat_t;

	// Echo controller states
	// Also exported at the top level
	typedef enum logic [1:0] {
		ECHO_IDLE  = 2'd0,
		ECHO_FETCH = 2'd1,
		ECHO_SEND  = 2'd2
	} echo_state_t;

endpackage

`default_nettype wire

// File: logic/uart_receiver.sv
`timescale 1ns/1ns
`default_nettype none

module uart_receiver (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 tick,
	input  logic                 rx,
	output uart_pkg::byte_beat_t rx_beat
);
	import uart_pkg::*;

	// Counter widths
	localparam int TW = $clog2(OVERSAMPLE);
	localparam int BW = $clog2(DATA_BITS);

	// Terminal counts
	localparam logic [TW-1:0] HALF_LAST = TW'(HALF_BIT - 1);
	localparam logic [TW-1:0] BIT_LAST  = TW'(OVERSAMPLE - 1);
	localparam logic [BW-1:0] DATA_LAST = BW'(DATA_BITS - 1);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t            state;
	logic                 rx_meta;
	logic                 rx_sync;
	logic [TW-1:0]        tick_cnt;
	logic [BW-1:0]        bit_cnt;
	logic [DATA_BITS-1:0] shift;
	logic                 bit_sample;
	logic                 stop_sample;

	//////////////////////////////////////////////////
	// Input synchronizer
	//////////////////////////////////////////////////

	// Two flops, line idles high
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	//////////////////////////////////////////////////
	// Frame state machine
	//////////////////////////////////////////////////

	// Mid-bit sample points
	assign bit_sample  = tick && (state == RX_DATA) && (tick_cnt == BIT_LAST);
	assign stop_sample = tick && (state == RX_STOP) && (tick_cnt == BIT_LAST);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state    <= RX_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
		end
		else if (tick)
		begin
			case (state)
				RX_IDLE:
				begin
					tick_cnt <= '0;
					bit_cnt  <= '0;
					// Falling edge seen, maybe a start bit
					if (!rx_sync)
						state <= RX_START;
				end
				RX_START:
				begin
					if (tick_cnt == HALF_LAST)
					begin
						tick_cnt <= '0;
						// Back high at mid-bit means glitch
						state <= rx_sync ? RX_IDLE : RX_DATA;
					end
					else
						tick_cnt <= tick_cnt + 1'b1;
				end
				RX_DATA:
				begin
					if (tick_cnt == BIT_LAST)
					begin
						tick_cnt <= '0;
						bit_cnt  <= bit_cnt + 1'b1;
						if (bit_cnt == DATA_LAST)
							state <= RX_STOP;
					end
					else
						tick_cnt <= tick_cnt + 1'b1;
				end
				RX_STOP:
				begin
					// Back to idle at mid stop bit
					if (tick_cnt == BIT_LAST)
						state <= RX_IDLE;
					else
						tick_cnt <= tick_cnt + 1'b1;
				end
				default:
					state <= RX_IDLE;
			endcase
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clk)
	begin
		if (bit_sample)
			shift <= {rx_sync, shift[DATA_BITS-1:1]};
	end

	// Low stop bit is a framing error, byte dropped
	assign rx_beat = '{valid: stop_sample && rx_sync, data: shift};

endmodule

`default_nettype wire

// File: logic/uart_transmitter.sv
`timescale 1ns/1ns
`default_nettype none

module uart_transmitter (
	input  logic       clk,
	input  logic       rst,
	input  logic       tick,
	input  logic [7:0] tx_head,
	input  logic       tx_empty,
	output logic       tx_pop,
	output logic       tx_line
);
	import uart_pkg::*;

	// Start bit, data bits, stop bit
	localparam int FRAME_BITS = DATA_BITS + 2;
	localparam int TW = $clog2(OVERSAMPLE);
	localparam int FW = $clog2(FRAME_BITS);
	localparam logic [TW-1:0] BIT_LAST   = TW'(OVERSAMPLE - 1);
	localparam logic [FW-1:0] FRAME_LAST = FW'(FRAME_BITS - 1);

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_ARMED,
		TX_SEND
	} tx_state_t;

	tx_state_t             state;
	logic [TW-1:0]         tick_cnt;
	logic [FW-1:0]         bit_cnt;
	logic [FRAME_BITS-1:0] frame;
	logic                  bit_end;

	// Take a byte whenever idle and one is waiting
	assign tx_pop = (state == TX_IDLE) && !tx_empty;

	// Last tick of the current bit period
	assign bit_end = (state == TX_SEND) && tick && (tick_cnt == BIT_LAST);

	//////////////////////////////////////////////////
	// Bit timing
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state    <= TX_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
		end
		else
		begin
			case (state)
				TX_IDLE:
				begin
					if (tx_pop)
						state <= TX_ARMED;
				end
				TX_ARMED:
				begin
					// Frame begins on a tick boundary
					if (tick)
					begin
						state    <= TX_SEND;
						tick_cnt <= '0;
						bit_cnt  <= '0;
					end
				end
				TX_SEND:
				begin
					if (bit_end)
					begin
						tick_cnt <= '0;
						bit_cnt  <= bit_cnt + 1'b1;
						// Stop bit done
						if (bit_cnt == FRAME_LAST)
							state <= TX_IDLE;
					end
					else if (tick)
						tick_cnt <= tick_cnt + 1'b1;
				end
				default:
					state <= TX_IDLE;
			endcase
		end
	end

	// Framed word, shifted out LSB first, ones fill from the top
	always_ff @(posedge clk)
	begin
		if (tx_pop)
			frame <= {1'b1, tx_head, 1'b0};
		else if (bit_end)
			frame <= {1'b1, frame[FRAME_BITS-1:1]};
	end

	// Line idles high outside a frame
	assign tx_line = (state == TX_SEND) ? frame[0] : 1'b1;

endmodule

`default_nettype wire

// File: src.f
logic/uart_pkg.sv
logic/baud_tick_gen.sv
logic/uart_receiver.sv
logic/byte_fifo.sv
logic/echo_controller.sv
logic/uart_transmitter.sv
logic/uart_echo_top.sv
tb/uart_echo_properties.sv
tb/uart_echo_tb.sv

// File: tb/uart_echo_properties.sv
`timescale 1ns/1ns
`default_nettype none

module uart_echo_properties (
	input logic                  clk,
	input logic                  rst,
	input logic                  rx_empty,
	input logic                  tx_full,
	input logic                  rx_pop,
	input uart_pkg::byte_beat_t  tx_beat,
	input uart_pkg::echo_state_t state
);
	import uart_pkg::*;

	// Failed assertion count
	int unsigned failures = 0;

	//////////////////////////////////////////////////
	// Controller handshake rules
	//////////////////////////////////////////////////

	// Never pop an empty receive FIFO
	a_pop_not_empty: assert property (@(posedge clk) disable iff (rst) rx_pop |-> !rx_empty)
	else
	begin
		$error("Receive FIFO popped while empty");
		failures++;
	end

	// Never push into a full transmit FIFO
	a_push_not_full: assert property (@(posedge clk) disable iff (rst) tx_beat.valid |-> !tx_full)
	else
	begin
		$error("Transmit FIFO pushed while full");
		failures++;
	end

	// Only the three encoded states
	a_state_legal: assert property (@(posedge clk) disable iff (rst)
		state inside {ECHO_IDLE, ECHO_FETCH, ECHO_SEND})
	else
	begin
		$error("Controller in an illegal state");
		failures++;
	end

	// Pop strobe is a single cycle
	a_pop_single: assert property (@(posedge clk) disable iff (rst) rx_pop |=> !rx_pop)
	else
	begin
		$error("rx_pop held high for more than one cycle");
		failures++;
	end

endmodule

bind echo_controller uart_echo_properties i_props (
	.clk      (clk),
	.rst      (rst),
	.rx_empty (rx_empty),
	.tx_full  (tx_full),
	.rx_pop   (rx_pop),
	.tx_beat  (tx_beat),
	.state    (state)
);

`default_nettype wire

// File: tb/uart_echo_tb.sv
`timescale 1ns/1ns
`default_nettype none

module uart_echo_tb;
	import uart_pkg::*;

	localparam int CLKS_PER_TICK = 2;
	localparam int FIFO_DEPTH    = 4;
	localparam int BIT_CLKS      = CLKS_PER_TICK * OVERSAMPLE;
	localparam int FRAME_CLKS    = BIT_CLKS * (DATA_BITS + 2);
	localparam int NUM_TESTS     = 12;
	localparam int TIMEOUT       = NUM_TESTS * 2 * FRAME_CLKS + 1000;

	// Frame kinds
	localparam logic [1:0] KIND_NORMAL      = 2'd0;
	localparam logic [1:0] KIND_FALSE_START = 2'd1;
	localparam logic [1:0] KIND_BAD_STOP    = 2'd2;

	// One table row with idle gap bits before the frame
	typedef struct packed {
		logic [1:0] kind;
		logic       rand_data;
		logic [1:0] gap_bits;
		logic [7:0] data;
	} stim_t;

	logic        clk;
	logic        rst;
	logic        rx;
	logic        tx;
	echo_state_t echo_state;

	stim_t       stim [NUM_TESTS];
	string       names [NUM_TESTS];
	int          test_err [NUM_TESTS];
	logic [7:0]  exp_data [$];
	int          exp_test [$];
	logic [31:0] lfsr_state  = 32'hb6621b3c;
	int          errors      = 0;
	int          passed      = 0;
	int          next_report = 0;
	int          departures  = 0;
	int          echoed      = 0;
	int          cycles      = 0;

	uart_echo_top #(
		.CLKS_PER_TICK (CLKS_PER_TICK),
		.FIFO_DEPTH    (FIFO_DEPTH)
	) i_dut (
		.clk        (clk),
		.rst        (rst),
		.rx         (rx),
		.tx         (tx),
		.echo_state (echo_state)
	);

	// 4 ns clock
	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		begin
			fb = s[31] ^ s[21] ^ s[1] ^ s[0];
			lfsr_next = {s[30:0], fb};
		end
	endfunction

	// One LFSR step per payload bit
	task automatic take_random_byte(output logic [7:0] value);
		int i;
		begin
			for (i = 0; i < 8; i++)
			begin
				lfsr_state = lfsr_next(lfsr_state);
				value[i] = lfsr_state[0];
			end
		end
	endtask

	task automatic load_table();
		begin
			stim[0]  = '{KIND_NORMAL, 1'b0, 2'd1, 8'hA5};
			names[0] = "single_a5";
			stim[1]  = '{KIND_NORMAL, 1'b0, 2'd1, 8'h00};
			names[1] = "gap_00";
			// Back to back run
			stim[2]  = '{KIND_NORMAL, 1'b0, 2'd0, 8'hFF};
			names[2] = "b2b_ff";
			stim[3]  = '{KIND_NORMAL, 1'b1, 2'd0, 8'h00};
			names[3] = "b2b_rand_0";
			stim[4]  = '{KIND_NORMAL, 1'b1, 2'd0, 8'h00};
			names[4] = "b2b_rand_1";
			stim[5]  = '{KIND_NORMAL, 1'b1, 2'd0, 8'h00};
			names[5] = "b2b_rand_2";
			// Dropped frames each followed by a good one
			stim[6]  = '{KIND_FALSE_START, 1'b0, 2'd1, 8'h00};
			names[6] = "false_start";
			stim[7]  = '{KIND_NORMAL, 1'b0, 2'd1, 8'h3C};
			names[7] = "after_false";
			stim[8]  = '{KIND_BAD_STOP, 1'b0, 2'd1, 8'h81};
			names[8] = "bad_stop";
			stim[9]  = '{KIND_NORMAL, 1'b0, 2'd1, 8'h5A};
			names[9] = "after_bad";
			stim[10]  = '{KIND_NORMAL, 1'b1, 2'd1, 8'h00};
			names[10] = "rand_3";
			stim[11]  = '{KIND_NORMAL, 1'b0, 2'd2, 8'h7E};
			names[11] = "final_7e";
		end
	endtask

	// Entered and left 1 ns after a rising edge
	task automatic hold_line(input logic level, input int clocks);
		begin
			if (clocks > 0)
			begin
				rx = level;
				repeat (clocks) @(posedge clk);
				#1;
			end
		end
	endtask

	task automatic send_entry(input int idx);
		stim_t      s;
		logic [7:0] value;
		int         b;
		begin
			s = stim[idx];
			value = s.data;
			if (s.rand_data)
				take_random_byte(value);
			hold_line(1'b1, s.gap_bits * BIT_CLKS);
			if (s.kind == KIND_FALSE_START)
			begin
				// Quarter bit low and well short of mid-bit
				hold_line(1'b0, BIT_CLKS / 4);
				hold_line(1'b1, BIT_CLKS);
			end
			else
			begin
				// Only good frames come back
				if (s.kind == KIND_NORMAL)
				begin
					exp_data.push_back(value);
					exp_test.push_back(idx);
				end
				hold_line(1'b0, BIT_CLKS);
				for (b = 0; b < 8; b++)
					hold_line(value[b], BIT_CLKS);
				hold_line(s.kind != KIND_BAD_STOP, BIT_CLKS);
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Result checking
	//////////////////////////////////////////////////

	// Reports every test up to and including upto
	task automatic finish_tests(input int upto);
		begin
			while (next_report <= upto)
			begin
				if (test_err[next_report] == 0)
					passed++;
				$display("Test %0d %s: %s", next_report, names[next_report],
					(test_err[next_report] == 0) ? "ok" : "mismatch");
				next_report++;
			end
		end
	endtask

	// Matched by order since latency is not fixed
	task automatic check_byte(input logic [7:0] got);
		logic [7:0] want;
		int         idx;
		begin
			assert (exp_data.size() > 0)
			else
			begin
				$display("Extra byte %h came out on tx with nothing left to echo", got);
				errors++;
			end
			if (exp_data.size() > 0)
			begin
				want = exp_data.pop_front();
				idx = exp_test.pop_front();
				echoed++;
				assert (got === want)
				else
				begin
					$display("Error %s expected %h actual %h", names[idx], want, got);
					errors++;
					test_err[idx]++;
				end
				finish_tests(idx);
			end
		end
	endtask

	// tx monitor sampling on falling edges
	initial
	begin
		logic [7:0] got;
		int         b;
		wait (rst === 1'b0);
		forever
		begin
			@(negedge clk);
			if (tx === 1'b0)
			begin
				repeat (BIT_CLKS / 2) @(negedge clk);
				assert (tx === 1'b0)
				else
				begin
					$display("Start bit on tx went high before mid-bit");
					errors++;
				end
				if (tx === 1'b0)
				begin
					for (b = 0; b < 8; b++)
					begin
						repeat (BIT_CLKS) @(negedge clk);
						got[b] = tx;
					end
					repeat (BIT_CLKS) @(negedge clk);
					assert (tx === 1'b1)
					else
					begin
						$display("Stop bit on tx was low after byte %h", got);
						errors++;
					end
					check_byte(got);
				end
			end
		end
	end

	// Count exits from idle
	initial
	begin
		echo_state_t prev;
		prev = ECHO_IDLE;
		wait (rst === 1'b0);
		forever
		begin
			@(negedge clk);
			if (prev == ECHO_IDLE && echo_state != ECHO_IDLE)
				departures++;
			prev = echo_state;
		end
	end

	// Run limit
	initial
	begin
		while (cycles < TIMEOUT)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d clock cycles, run did not finish", TIMEOUT);
		$display("Simulation FAILED");
		$finish;
	end

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial
	begin
		int         i;
		bit         reset_bad;
		int         miss_idx;
		logic [7:0] miss_byte;
		rst = 1'b1;
		rx = 1'b1;
		reset_bad = 1'b0;
		load_table();
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		// Quiet line after reset
		repeat (2 * BIT_CLKS)
		begin
			@(negedge clk);
			assert (tx === 1'b1 && echo_state === ECHO_IDLE)
			else
			begin
				if (!reset_bad)
				begin
					$display("Error reset_idle expected tx=1 ECHO_IDLE actual tx=%b %s",
						tx, echo_state.name());
					errors++;
				end
				reset_bad = 1'b1;
			end
		end
		if (!reset_bad)
			passed++;
		$display("Test reset_idle: %s", reset_bad ? "mismatch" : "ok");
		@(posedge clk);
		#1;
		for (i = 0; i < NUM_TESTS; i++)
			send_entry(i);
		// Two frame times of silence on rx
		repeat (2 * FRAME_CLKS) @(negedge clk);
		assert (exp_data.size() == 0)
		else
		begin
			while (exp_data.size() > 0)
			begin
				miss_byte = exp_data.pop_front();
				miss_idx = exp_test.pop_front();
				$display("Byte %h of test %s never came back on tx", miss_byte, names[miss_idx]);
				test_err[miss_idx]++;
				errors++;
			end
		end
		assert (echo_state === ECHO_IDLE)
		else
		begin
			$display("Error quiet_state expected ECHO_IDLE actual %s", echo_state.name());
			errors++;
		end
		assert (departures >= echoed)
		else
		begin
			$display("Controller left idle %0d times for %0d echoed bytes", departures, echoed);
			errors++;
		end
		finish_tests(NUM_TESTS - 1);
		errors += i_dut.i_controller.i_props.failures;
		$display("Summary: %0d tests, %0d passed, %0d errors", NUM_TESTS + 1, passed, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire
